// ==== list.f ====
logic/usbEpPkg.sv
logic/dataPacketFramer.sv
logic/dataToggleTracker.sv
logic/transFifo.sv
logic/usbEndpointIn.sv
logic/usbEpSubsystem.sv
testbench/usbEpTb.sv

// ==== testbench/usbEpStim.txt ====
# pkt name pid success count random response bytes (response is ack nak stall or none)
# pop name count release bytes (release 0 rewinds) and rst name pulses the toggle reset

# Plain DATA0 packet read back in full
pkt firstData0 c3 1 4 0 ack 11 22 33 44
pop readFirst 4 1 11 22 33 44

# Repeat of an accepted packet is answered but not stored
pkt repeatData0 c3 1 4 0 ack 11 22 33 44
pkt nextData1 4b 1 3 0 ack a1 a2 a3
pop readData1 3 1 a1 a2 a3

# Corrupted packet leaves the toggle alone so the resend is stored
pkt crcFail c3 0 2 0 none 55 66
pkt resendData0 c3 1 2 0 ack 55 66
pop readResend 2 1 55 66

# Oversized packet is dropped and older data survives
pkt keepData1 4b 1 3 0 ack b1 b2 b3
pkt overflowData0 c3 1 520 1 nak
pop readKept 3 1 b1 b2 b3

# Failed pop transaction rewinds, a good one releases
pkt rewindData0 c3 1 2 0 ack d1 d2
pop rewindRead 2 0 d1 d2
pop releaseRead 2 1 d1 d2

# Toggle reset and a PID with a broken check nibble
rst toggleReset
pkt afterReset c3 1 2 0 ack e1 e2
pkt badCheck d3 1 2 0 none f1 f2
pop readAfterReset 2 1 e1 e2

// ==== testbench/usbEpTb.sv ====
module usbEpTb;

    timeunit 1ns;
    timeprecision 100ps;

    logic clk12_i;
    logic arstN_i;
    logic gotTransStartPacket_i;
    logic rxDataValid_i;
    logic [usbEpPkg::DATA_WID-1:0] rxData_i;
    logic fillTransDone_i;
    logic fillTransSuccess_i;
    logic resetDataToggle_i;
    logic popData_i;
    logic popTransDone_i;
    logic popTransSuccess_i;
    logic full_o;
    logic dataAvailable_o;
    logic [usbEpPkg::DATA_WID-1:0] data_o;
    logic respValid_o;
    logic [1:0] respPacketID_o;

    // Committed bytes not yet released, oldest first
    logic [usbEpPkg::DATA_WID-1:0] model[$];
    // Toggle bit that the next new packet must carry
    bit expToggle;
    int fd;
    int errors;
    int passCount;
    int failCount;

    usbEpSubsystem DUT (
        .clk12_i(clk12_i),
        .arstN_i(arstN_i),
        .gotTransStartPacket_i(gotTransStartPacket_i),
        .rxDataValid_i(rxDataValid_i),
        .rxData_i(rxData_i),
        .fillTransDone_i(fillTransDone_i),
        .fillTransSuccess_i(fillTransSuccess_i),
        .resetDataToggle_i(resetDataToggle_i),
        .popData_i(popData_i),
        .popTransDone_i(popTransDone_i),
        .popTransSuccess_i(popTransSuccess_i),
        .full_o(full_o),
        .dataAvailable_o(dataAvailable_o),
        .data_o(data_o),
        .respValid_o(respValid_o),
        .respPacketID_o(respPacketID_o)
    );

    initial begin
        clk12_i = 1'b0;
        forever #2 clk12_i = ~clk12_i;
    end

    task automatic logMismatch(input string name, input logic [31:0] expVal,
                               input logic [31:0] actVal);
        errors++;
        $display("MISMATCH %s expected %0h actual %0h", name, expVal, actVal);
    endtask

    task automatic logFailure(input string name, input string what);
        errors++;
        $display("ERROR %s %s", name, what);
    endtask

    // Response word of the stim file, -1 when no handshake is expected
    function automatic int respFromText(input string text);
        if (text == "none") return -1;
        if (text == "ack") return usbEpPkg::RES_ACK;
        if (text == "nak") return usbEpPkg::RES_NAK;
        if (text == "stall") return usbEpPkg::RES_STALL;
        return -2;
    endfunction

    task automatic waitAvailable(input string name, output bit ok);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk12_i);
            cycles++;
        end while (!dataAvailable_o && cycles < 2000);
        ok = dataAvailable_o;
        if (!ok) logFailure(name, "timed out waiting for dataAvailable_o");
    endtask

    task automatic sendPacket(input string name);
        logic [usbEpPkg::DATA_WID-1:0] pid;
        logic [usbEpPkg::DATA_WID-1:0] oneByte;
        logic [usbEpPkg::DATA_WID-1:0] bytes[$];
        string respText;
        int succ;
        int count;
        int rnd;
        int fileCode;
        int expCode;
        int cycles;
        bit pidValid;
        bit pidToggle;
        bit store;
        bit overflow;
        bit sawFull;
        void'($fscanf(fd, "%h %d %d %d %s", pid, succ, count, rnd, respText));
        for (int i = 0; i < count; i++) begin
            if (rnd != 0) begin
                oneByte = $urandom;
            end else begin
                void'($fscanf(fd, "%h", oneByte));
            end
            bytes.push_back(oneByte);
        end
        fileCode = respFromText(respText);
        if (fileCode == -2) logFailure(name, "unknown response word in the stim file");

        // Only the two data PID codes are valid here
        // DATA1 is the one that carries the set toggle
        pidValid = (pid == usbEpPkg::PID_DATA0) || (pid == usbEpPkg::PID_DATA1);
        pidToggle = (pid == usbEpPkg::PID_DATA1);
        store = 1'b0;
        overflow = 1'b0;
        if (succ == 0 || !pidValid) begin
            expCode = -1;
        end else if (pidToggle != expToggle) begin
            // Host resent a packet whose ACK it missed
            expCode = usbEpPkg::RES_ACK;
        end else if (count > (1 << usbEpPkg::FIFO_ADDR_WID) - model.size()) begin
            overflow = 1'b1;
            expCode = usbEpPkg::RES_NAK;
        end else begin
            store = 1'b1;
            expCode = usbEpPkg::RES_ACK;
        end
        if (expCode != fileCode) logMismatch({name, " model response"}, fileCode, expCode);

        // Start pulse, then the PID and the payload on back to back cycles
        @(posedge clk12_i);
        gotTransStartPacket_i <= 1'b1;
        @(posedge clk12_i);
        gotTransStartPacket_i <= 1'b0;
        rxDataValid_i <= 1'b1;
        rxData_i <= pid;
        foreach (bytes[i]) begin
            @(posedge clk12_i);
            rxData_i <= bytes[i];
        end
        @(posedge clk12_i);
        rxDataValid_i <= 1'b0;
        @(negedge clk12_i);
        sawFull = full_o;
        if (overflow && !sawFull) logFailure(name, "full_o did not rise during the oversized packet");

        @(posedge clk12_i);
        fillTransDone_i <= 1'b1;
        fillTransSuccess_i <= (succ != 0);
        @(posedge clk12_i);
        fillTransDone_i <= 1'b0;
        fillTransSuccess_i <= 1'b0;

        if (expCode < 0) begin
            // A dropped transaction must stay silent
            repeat (8) begin
                @(negedge clk12_i);
                if (respValid_o) logFailure(name, "respValid_o pulsed for a dropped packet");
            end
        end else begin
            cycles = 0;
            do begin
                @(negedge clk12_i);
                cycles++;
            end while (!respValid_o && cycles < 2000);
            if (!respValid_o) begin
                logFailure(name, "timed out waiting for respValid_o");
            end else begin
                if (cycles != 1) logFailure(name, "response did not follow done by one cycle");
                if (respPacketID_o !== expCode[1:0]) begin
                    logMismatch({name, " response"}, expCode, respPacketID_o);
                end
            end
        end
        if (overflow && full_o) logFailure(name, "full_o stayed high after the rollback");

        if (store) begin
            foreach (bytes[i]) model.push_back(bytes[i]);
            expToggle = !expToggle;
        end
    endtask

    task automatic popPacket(input string name);
        logic [usbEpPkg::DATA_WID-1:0] fileByte;
        int count;
        int keep;
        bit ok;
        void'($fscanf(fd, "%d %d", count, keep));
        for (int i = 0; i < count; i++) begin
            void'($fscanf(fd, "%h", fileByte));
            if (i >= model.size()) logFailure(name, "model holds fewer bytes than the stim file");
            else if (model[i] !== fileByte) logMismatch({name, " model byte"}, fileByte, model[i]);
            waitAvailable(name, ok);
            if (ok) begin
                if (data_o !== fileByte) logMismatch({name, " data"}, fileByte, data_o);
                @(posedge clk12_i);
                popData_i <= 1'b1;
                @(posedge clk12_i);
                popData_i <= 1'b0;
            end
        end
        // Nothing left unread means the availability flag has to drop
        @(negedge clk12_i);
        if (model.size() <= count && dataAvailable_o) begin
            logFailure(name, "dataAvailable_o still high after the last byte");
        end
        @(posedge clk12_i);
        popTransDone_i <= 1'b1;
        popTransSuccess_i <= (keep != 0);
        @(posedge clk12_i);
        popTransDone_i <= 1'b0;
        popTransSuccess_i <= 1'b0;
        if (keep != 0) begin
            for (int i = 0; i < count && model.size() > 0; i++) void'(model.pop_front());
        end
    endtask

    task automatic pulseToggleReset();
        @(posedge clk12_i);
        resetDataToggle_i <= 1'b1;
        @(posedge clk12_i);
        resetDataToggle_i <= 1'b0;
        expToggle = 1'b0;
    endtask

    initial begin
        string cmd;
        string name;
        int errBefore;
        arstN_i = 1'b0;
        gotTransStartPacket_i = 1'b0;
        rxDataValid_i = 1'b0;
        rxData_i = '0;
        fillTransDone_i = 1'b0;
        fillTransSuccess_i = 1'b0;
        resetDataToggle_i = 1'b0;
        popData_i = 1'b0;
        popTransDone_i = 1'b0;
        popTransSuccess_i = 1'b0;
        errors = 0;
        passCount = 0;
        failCount = 0;
        expToggle = 1'b0;
        void'($urandom(32'hd9fd));

        repeat (16) @(posedge clk12_i);
        arstN_i <= 1'b1;
        @(negedge clk12_i);
        if (respValid_o || dataAvailable_o || full_o) logFailure("reset", "outputs not idle");

        fd = $fopen("testbench/usbEpStim.txt", "r");
        if (fd == 0) begin
            logFailure("stim", "could not open testbench/usbEpStim.txt");
        end else begin
            while ($fscanf(fd, "%s", cmd) == 1) begin
                // Comment lines are skipped whole
                if (cmd.getc(0) == "#") begin
                    void'($fgets(cmd, fd));
                    continue;
                end
                void'($fscanf(fd, "%s", name));
                errBefore = errors;
                if (cmd == "pkt") begin
                    sendPacket(name);
                end else if (cmd == "pop") begin
                    popPacket(name);
                end else if (cmd == "rst") begin
                    pulseToggleReset();
                end else begin
                    logFailure(name, {"unknown command ", cmd});
                    break;
                end
                if (errors == errBefore) begin
                    passCount++;
                    $display("PASS %s", name);
                end else begin
                    failCount++;
                    $display("FAIL %s", name);
                end
            end
            $fclose(fd);
        end

        $display("Tests passed %0d failed %0d", passCount, failCount);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== logic/usbEpSubsystem.sv ====
module usbEpSubsystem (
    input logic clk12_i,
    input logic arstN_i,
    input logic gotTransStartPacket_i,
    input logic rxDataValid_i,
    input logic [usbEpPkg::DATA_WID-1:0] rxData_i,
    input logic fillTransDone_i,
    input logic fillTransSuccess_i,
    input logic resetDataToggle_i,
    input logic popData_i,
    input logic popTransDone_i,
    input logic popTransSuccess_i,
    output logic full_o,
    output logic dataAvailable_o,
    output logic [usbEpPkg::DATA_WID-1:0] data_o,
    output logic respValid_o,
    output logic [1:0] respPacketID_o
);

    // Framer results for the packet in flight
    logic byteIsData;
    logic pidStrobe;
    logic pidToggle;
    logic pidOk;

    // Splits each packet into its PID and payload
    dataPacketFramer framer (
        .clk12_i(clk12_i),
        .arstN_i(arstN_i),
        .gotTransStartPacket_i(gotTransStartPacket_i),
        .rxDataValid_i(rxDataValid_i),
        .rxData_i(rxData_i),
        .byteIsData_o(byteIsData),
        .pidStrobe_o(pidStrobe),
        .pidToggle_o(pidToggle),
        .pidOk_o(pidOk)
    );

    // Stores the payload and answers each transaction
    usbEndpointIn endpoint (
        .clk12_i(clk12_i),
        .arstN_i(arstN_i),
        .byteIsData_i(byteIsData),
        .pidStrobe_i(pidStrobe),
        .pidToggle_i(pidToggle),
        .pidOk_i(pidOk),
        .rxDataValid_i(rxDataValid_i),
        .rxData_i(rxData_i),
        .resetDataToggle_i(resetDataToggle_i),
        .fillTransDone_i(fillTransDone_i),
        .fillTransSuccess_i(fillTransSuccess_i),
        .popData_i(popData_i),
        .popTransDone_i(popTransDone_i),
        .popTransSuccess_i(popTransSuccess_i),
        .full_o(full_o),
        .dataAvailable_o(dataAvailable_o),
        .data_o(data_o),
        .respValid_o(respValid_o),
        .respPacketID_o(respPacketID_o)
    );

endmodule

// ==== logic/usbEndpointIn.sv ====
module usbEndpointIn (
    input logic clk12_i,
    input logic arstN_i,
    input logic byteIsData_i,
    input logic pidStrobe_i,
    input logic pidToggle_i,
    input logic pidOk_i,
    input logic rxDataValid_i,
    input logic [usbEpPkg::DATA_WID-1:0] rxData_i,
    input logic resetDataToggle_i,
    input logic fillTransDone_i,
    input logic fillTransSuccess_i,
    input logic popData_i,
    input logic popTransDone_i,
    input logic popTransSuccess_i,
    output logic full_o,
    output logic dataAvailable_o,
    output logic [usbEpPkg::DATA_WID-1:0] data_o,
    output logic respValid_o,
    output logic [1:0] respPacketID_o
);

    // PID verdict of the current packet, kept until its transaction ends
    logic pidGood;
    // Set when a payload byte could not be stored
    logic overflow;
    // Handshake chosen for a successful transaction of this endpoint type
    logic [1:0] respCode;

    generate
        if (usbEpPkg::EP_TYPE != usbEpPkg::NONE) begin : genStore
            // Packet is a resend and its bytes are skipped
            logic ignore;
            // Byte written into the FIFO this cycle
            logic wrStrobe;
            // Whole transaction is good enough to keep its bytes
            logic fillCommit;
            // Transaction accepted as new data, which moves the toggle sequence
            logic commitStrobe;

            // Payload bytes are stored unless the packet is a resend or has already lost a byte
            assign wrStrobe = rxDataValid_i && byteIsData_i && !ignore && !overflow && !full_o;
            assign fillCommit = fillTransSuccess_i && pidGood && !overflow;
            assign commitStrobe = fillTransDone_i && fillCommit && !ignore;

            if (usbEpPkg::EP_TYPE == usbEpPkg::ISOCHRONOUS) begin : genIso
                // Isochronous data carries no retry, so every packet is new
                assign ignore = 1'b0;
            end else begin : genToggle
                dataToggleTracker toggleTracker (
                    .clk12_i(clk12_i),
                    .arstN_i(arstN_i),
                    .resetDataToggle_i(resetDataToggle_i),
                    .pidStrobe_i(pidStrobe_i),
                    .pidToggle_i(pidToggle_i),
                    .commitStrobe_i(commitStrobe),
                    .ignore_o(ignore)
                );
            end

            transFifo rxFifo (
                .clk12_i(clk12_i),
                .arstN_i(arstN_i),
                .wrStrobe_i(wrStrobe),
                .wrData_i(rxData_i),
                .fillDone_i(fillTransDone_i),
                .fillCommit_i(fillCommit),
                .popData_i(popData_i),
                .popDone_i(popTransDone_i),
                .popCommit_i(popTransSuccess_i),
                .full_o(full_o),
                .dataAvailable_o(dataAvailable_o),
                .data_o(data_o)
            );

            always_ff @(posedge clk12_i or negedge arstN_i) begin
                if (!arstN_i) begin
                    overflow <= 1'b0;
                end else if (pidStrobe_i) begin
                    // Each packet starts without lost bytes
                    overflow <= 1'b0;
                end else if (rxDataValid_i && byteIsData_i && !ignore && full_o) begin
                    // No back-pressure exists on USB, so a byte seen while full is lost
                    overflow <= 1'b1;
                end
            end

            // A lost byte makes the host retry later, otherwise the data is acknowledged
            assign respCode = overflow ? usbEpPkg::RES_NAK : usbEpPkg::RES_ACK;
        end else begin : genStall
            // Endpoint not in use, nothing is stored and every transaction is refused
            assign full_o = 1'b0;
            assign dataAvailable_o = 1'b0;
            assign data_o = '0;
            assign overflow = 1'b0;
            assign respCode = usbEpPkg::RES_STALL;
        end
    endgenerate

    always_ff @(posedge clk12_i or negedge arstN_i) begin
        if (!arstN_i) begin
            pidGood <= 1'b0;
            respValid_o <= 1'b0;
            respPacketID_o <= usbEpPkg::RES_ACK;
        end else begin
            if (pidStrobe_i) begin
                pidGood <= pidOk_i;
            end

            // Corrupted packets or bad PIDs stay unanswered so the host times out
            respValid_o <= fillTransDone_i && fillTransSuccess_i && pidGood;

            if (fillTransDone_i) begin
                respPacketID_o <= respCode;
            end
        end
    end

endmodule

// ==== logic/transFifo.sv ====
module transFifo (
    input logic clk12_i,
    input logic arstN_i,
    input logic wrStrobe_i,
    input logic [usbEpPkg::DATA_WID-1:0] wrData_i,
    input logic fillDone_i,
    input logic fillCommit_i,
    input logic popData_i,
    input logic popDone_i,
    input logic popCommit_i,
    output logic full_o,
    output logic dataAvailable_o,
    output logic [usbEpPkg::DATA_WID-1:0] data_o
);

    // Byte storage, written by the fill side and read by the pop side
    logic [usbEpPkg::DATA_WID-1:0] mem [0:2**usbEpPkg::FIFO_ADDR_WID-1];

    // Pointers carry one extra wrap bit to tell a full FIFO from an empty one
    // Working write pointer, advanced by every stored byte
    logic [usbEpPkg::FIFO_ADDR_WID:0] wrPtr;
    // Write position of the last committed transaction
    logic [usbEpPkg::FIFO_ADDR_WID:0] wrPtrCommit;
    // Working read pointer, advanced by every pop
    logic [usbEpPkg::FIFO_ADDR_WID:0] rdPtr;
    // Read position up to which bytes are released for reuse
    logic [usbEpPkg::FIFO_ADDR_WID:0] rdPtrRelease;

    // Values the working pointers take at the next edge
    logic [usbEpPkg::FIFO_ADDR_WID:0] wrPtrNext;
    logic [usbEpPkg::FIFO_ADDR_WID:0] rdPtrNext;

    always_comb begin
        wrPtrNext = wrStrobe_i ? wrPtr + 1'b1 : wrPtr;
        // A failed fill drops every byte written since the last commit
        if (fillDone_i && !fillCommit_i) begin
            wrPtrNext = wrPtrCommit;
        end
    end

    always_comb begin
        rdPtrNext = popData_i ? rdPtr + 1'b1 : rdPtr;
        // A failed pop transaction goes back to the last released byte
        if (popDone_i && !popCommit_i) begin
            rdPtrNext = rdPtrRelease;
        end
    end

    always_ff @(posedge clk12_i or negedge arstN_i) begin
        if (!arstN_i) begin
            wrPtr <= '0;
            wrPtrCommit <= '0;
            rdPtr <= '0;
            rdPtrRelease <= '0;
        end else begin
            wrPtr <= wrPtrNext;
            rdPtr <= rdPtrNext;

            // Committed bytes become visible to the pop side from the next cycle
            if (fillDone_i && fillCommit_i) begin
                wrPtrCommit <= wrPtrNext;
            end

            // Released bytes free their entries for the fill side
            if (popDone_i && popCommit_i) begin
                rdPtrRelease <= rdPtrNext;
            end
        end
    end

    always_ff @(posedge clk12_i) begin
        if (wrStrobe_i) begin
            mem[wrPtr[usbEpPkg::FIFO_ADDR_WID-1:0]] <= wrData_i;
        end
        // Read ahead at the next pointer so the head byte is ready one cycle after a pop
        // The read runs every cycle, so a freshly filled head entry is picked up before commit
        data_o <= mem[rdPtrNext[usbEpPkg::FIFO_ADDR_WID-1:0]];
    end

    // Full when the write pointer is one lap ahead of the released read position
    assign full_o = (wrPtr[usbEpPkg::FIFO_ADDR_WID] != rdPtrRelease[usbEpPkg::FIFO_ADDR_WID])
                 && (wrPtr[usbEpPkg::FIFO_ADDR_WID-1:0]
                     == rdPtrRelease[usbEpPkg::FIFO_ADDR_WID-1:0]);

    // Only committed bytes are offered to the application
    assign dataAvailable_o = rdPtr != wrPtrCommit;

    // The endpoint must drop bytes itself once the FIFO is full
    noWriteWhenFull: assert property (
        @(posedge clk12_i) disable iff (!arstN_i)
        wrStrobe_i |-> !full_o
    ) else $error("Write strobe while FIFO is full");

    // The application may only pop bytes that are offered
    noPopWhenEmpty: assert property (
        @(posedge clk12_i) disable iff (!arstN_i)
        popData_i |-> dataAvailable_o
    ) else $error("Pop without available data");

endmodule

// ==== logic/dataToggleTracker.sv ====
module dataToggleTracker (
    input logic clk12_i,
    input logic arstN_i,
    input logic resetDataToggle_i,
    input logic pidStrobe_i,
    input logic pidToggle_i,
    input logic commitStrobe_i,
    output logic ignore_o
);

    // Toggle bit the next new packet has to carry
    logic expectedToggle;

    always_ff @(posedge clk12_i or negedge arstN_i) begin
        if (!arstN_i) begin
            ignore_o <= 1'b0;
            expectedToggle <= 1'b0;
        end else begin
            // A packet with the other toggle is a resend of data already stored
            // The host missed our ACK, so it is answered but not stored again
            if (pidStrobe_i) begin
                ignore_o <= pidToggle_i != expectedToggle;
            end

            // A configuration event puts the sequence back to DATA0
            if (resetDataToggle_i) begin
                expectedToggle <= 1'b0;
            end else if (commitStrobe_i) begin
                // Each accepted packet flips the sequence
                expectedToggle <= ~expectedToggle;
            end
        end
    end

endmodule

// ==== logic/dataPacketFramer.sv ====
module dataPacketFramer (
    input logic clk12_i,
    input logic arstN_i,
    input logic gotTransStartPacket_i,
    input logic rxDataValid_i,
    input logic [usbEpPkg::DATA_WID-1:0] rxData_i,
    output logic byteIsData_o,
    output logic pidStrobe_o,
    output logic pidToggle_o,
    output logic pidOk_o
);

    // High between a start pulse and the first byte that follows it
    logic pidNext;
    // Received byte seen through both views of the PID layout
    usbEpPkg::PidByte pidByte;

    assign pidByte.raw = rxData_i;

    // The first valid byte after a start pulse is the PID
    assign pidStrobe_o = pidNext && rxDataValid_i;

    // Toggle sits in the upper variant bit, DATA1 has it set
    assign pidToggle_o = pidByte.fields.variant[1];

    // A good data PID needs a matching check nibble, the data group and a clear low variant bit
    // Both data PIDs share the group and low variant bit, so either code serves as reference
    assign pidOk_o = (pidByte.fields.check == ~pidByte.raw[3:0])
                  && (pidByte.fields.group == usbEpPkg::PID_DATA0[1:0])
                  && (pidByte.fields.variant[0] == usbEpPkg::PID_DATA1[2]);

    always_ff @(posedge clk12_i or negedge arstN_i) begin
        if (!arstN_i) begin
            pidNext <= 1'b0;
            byteIsData_o <= 1'b0;
        end else begin
            if (gotTransStartPacket_i) begin
                // A new packet starts so the next byte must be decoded as PID
                pidNext <= 1'b1;
                byteIsData_o <= 1'b0;
            end else if (pidStrobe_o) begin
                // Everything after the PID is payload until the next start
                pidNext <= 1'b0;
                byteIsData_o <= 1'b1;
            end
        end
    end

    // A PID can only be seen once the payload phase of the previous packet has ended
    pidOutsidePayload: assert property (
        @(posedge clk12_i) disable iff (!arstN_i)
        $rose(pidStrobe_o) |-> !byteIsData_o
    ) else $error("PID strobe raised during payload phase");

endmodule

// ==== logic/usbEpPkg.sv ====
package usbEpPkg;

    // Depth of the receive FIFO as an address width, giving 512 bytes
    localparam int FIFO_ADDR_WID = 9;

    // Width of one received byte and of every data path in the endpoint
    localparam int DATA_WID = 8;

    // Raw data PIDs as they appear in the received byte
    // The low nibble is the PID type and the high nibble is its complement
    localparam logic [DATA_WID-1:0] PID_DATA0 = 8'hC3;
    localparam logic [DATA_WID-1:0] PID_DATA1 = 8'h4B;

    // Handshake codes handed to the transmit side
    localparam logic [1:0] RES_ACK = 2'b00;
    localparam logic [1:0] RES_NAK = 2'b10;
    localparam logic [1:0] RES_STALL = 2'b11;

    // Transfer type of this endpoint
    typedef enum logic [1:0] {
        NONE,
        BULK,
        ISOCHRONOUS
    } EpType;

    // Only the bulk setting is exercised in simulation
    localparam EpType EP_TYPE = BULK;

    // A PID byte read either as the raw byte or split into its fields
    // The field view follows the bit order of the received byte
    typedef union packed {
        logic [DATA_WID-1:0] raw;
        struct packed {
            // Must be the bitwise complement of the low nibble
            logic [3:0] check;
            // High bit is the data toggle and the low bit is 0 for data PIDs
            logic [1:0] variant;
            // 2'b11 marks a data packet
            logic [1:0] group;
        } fields;
    } PidByte;

endpackage
